// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_cpu_top
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx '\*\* PASS \*\*' $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: src.f
src/cpu_pkg.sv
src/stage_if.sv
src/ifu.sv
src/gpr.sv
src/idu.sv
src/exu.sv
src/cpu_top.sv
+incdir+verification
verification/tb_cpu_top.sv

// File: src/cpu_pkg.sv
package cpu_pkg;

    localparam int unsigned XLEN       = 32;
    localparam int unsigned REG_ADDR_W = 5;
    localparam int unsigned NUM_REGS   = 32;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    localparam word_t RESET_PC   = 32'h0000_0000;
    localparam word_t INST_BYTES = 32'd4;

    // major opcodes the core executes, anything else is a no-op
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS      // result is op2, used by lui
    } alu_op_e;

    typedef enum logic [3:0] {
        BJP_NONE,
        BJP_JAL,
        BJP_JALR,
        BJP_BEQ,
        BJP_BNE,
        BJP_BLT,
        BJP_BGE,
        BJP_BLTU,
        BJP_BGEU
    } bjp_op_e;

    typedef struct packed {
        word_t     pc;
        word_t     op1;
        word_t     op2;
        word_t     rs2_val;    // branch compare operand
        word_t     imm;
        alu_op_e   alu_op;
        bjp_op_e   bjp_op;
        reg_addr_t rd;
        logic      rd_we;
    } issue_t;

    typedef struct packed {
        logic      we;
        reg_addr_t waddr;
        word_t     wdata;
    } wb_t;

endpackage

// File: src/cpu_top.sv
`timescale 1ns/1ns

module cpu_top (
    input  logic               clk,
    input  logic               rst_n_i,
    input  cpu_pkg::word_t     inst_i,
    output cpu_pkg::word_t     inst_addr_o,
    output logic               wb_we_o,
    output cpu_pkg::reg_addr_t wb_waddr_o,
    output cpu_pkg::word_t     wb_wdata_o
);
    import cpu_pkg::*;

    stage_if #(.payload_t(word_t))  fetch_bus ();
    stage_if #(.payload_t(issue_t)) issue_bus ();

    logic      jump_flag;   // one-cycle redirect pulse from execute
    word_t     jump_addr;
    wb_t       wb;
    reg_addr_t raddr1, raddr2;
    word_t     rdata1, rdata2;

    ifu u_ifu (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .inst_i     (inst_i),
        .jump_flag_i(jump_flag),
        .jump_addr_i(jump_addr),
        .inst_addr_o(inst_addr_o),
        .fetch      (fetch_bus)
    );

    idu u_idu (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .fetch      (fetch_bus),
        .rdata1_i   (rdata1),
        .rdata2_i   (rdata2),
        .jump_flag_i(jump_flag),
        .raddr1_o   (raddr1),
        .raddr2_o   (raddr2),
        .issue      (issue_bus)
    );

    gpr u_gpr (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .wb_i    (wb),
        .raddr1_i(raddr1),
        .raddr2_i(raddr2),
        .rdata1_o(rdata1),
        .rdata2_o(rdata2)
    );

    exu u_exu (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .issue      (issue_bus),
        .jump_flag_o(jump_flag),
        .jump_addr_o(jump_addr),
        .wb_o       (wb)
    );

    assign wb_we_o    = wb.we;
    assign wb_waddr_o = wb.waddr;
    assign wb_wdata_o = wb.wdata;

endmodule

// File: src/exu.sv
`timescale 1ns/1ns

module exu (
    input  logic           clk,
    input  logic           rst_n_i,
    stage_if.consumer      issue,
    output logic           jump_flag_o,
    output cpu_pkg::word_t jump_addr_o,
    output cpu_pkg::wb_t   wb_o
);
    import cpu_pkg::*;

    issue_t     p;
    word_t      alu_res;
    logic [4:0] shamt;
    logic       taken;
    logic       is_jump;
    word_t      br_base;
    word_t      br_sum;
    word_t      link;

    assign p           = issue.payload;
    assign issue.stall = 1'b0;        // single-cycle execute, never holds issue
    assign shamt       = p.op2[4:0];

    always_comb begin
        case (p.alu_op)
            ALU_ADD:  alu_res = p.op1 + p.op2;
            ALU_SUB:  alu_res = p.op1 - p.op2;
            ALU_SLL:  alu_res = p.op1 << shamt;
            ALU_SLT:  alu_res = {31'b0, $signed(p.op1) < $signed(p.op2)};
            ALU_SLTU: alu_res = {31'b0, p.op1 < p.op2};
            ALU_XOR:  alu_res = p.op1 ^ p.op2;
            ALU_SRL:  alu_res = p.op1 >> shamt;
            ALU_SRA:  alu_res = $signed(p.op1) >>> shamt;
            ALU_OR:   alu_res = p.op1 | p.op2;
            ALU_AND:  alu_res = p.op1 & p.op2;
            ALU_PASS: alu_res = p.op2;
            default:  alu_res = '0;
        endcase
    end

    // branch condition, compares rs1 against rs2
    always_comb begin
        case (p.bjp_op)
            BJP_JAL,
            BJP_JALR: taken = 1'b1;
            BJP_BEQ:  taken = p.op1 == p.rs2_val;
            BJP_BNE:  taken = p.op1 != p.rs2_val;
            BJP_BLT:  taken = $signed(p.op1) <  $signed(p.rs2_val);
            BJP_BGE:  taken = $signed(p.op1) >= $signed(p.rs2_val);
            BJP_BLTU: taken = p.op1 <  p.rs2_val;
            BJP_BGEU: taken = p.op1 >= p.rs2_val;
            default:  taken = 1'b0;
        endcase
    end

    assign is_jump = p.bjp_op == BJP_JAL || p.bjp_op == BJP_JALR;
    assign br_base = (p.bjp_op == BJP_JALR) ? p.op1 : p.pc;  // jalr is rs1 relative
    assign br_sum  = br_base + p.imm;
    assign link    = issue.pc + INST_BYTES;

    // redirect is live only while the branch sits in the issue register
    assign jump_flag_o = issue.valid && taken;
    assign jump_addr_o = {br_sum[XLEN-1:1], 1'b0};

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            wb_o.we <= 1'b0;
        end else begin
            wb_o.we <= issue.valid && p.rd_we;
        end
        wb_o.waddr <= p.rd;
        wb_o.wdata <= is_jump ? link : alu_res;   // links write pc+4
    end

endmodule

// File: src/gpr.sv
`timescale 1ns/1ns

module gpr (
    input  logic                clk,
    input  logic                rst_n_i,
    input  cpu_pkg::wb_t        wb_i,
    input  cpu_pkg::reg_addr_t  raddr1_i,
    input  cpu_pkg::reg_addr_t  raddr2_i,
    output cpu_pkg::word_t      rdata1_o,
    output cpu_pkg::word_t      rdata2_o
);
    import cpu_pkg::*;

    word_t regs [NUM_REGS];

    // x0 reads zero, a register being written returns the new value
    function automatic word_t read_port(input reg_addr_t addr);
        if (addr == '0)
            return '0;
        if (wb_i.we && wb_i.waddr == addr)
            return wb_i.wdata;
        return regs[addr];
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < NUM_REGS; i++)
                regs[i] <= '0;
        end else if (wb_i.we && wb_i.waddr != '0) begin
            regs[wb_i.waddr] <= wb_i.wdata;
        end
    end

    assign rdata1_o = read_port(raddr1_i);
    assign rdata2_o = read_port(raddr2_i);

endmodule

// File: src/idu.sv
`timescale 1ns/1ns

module idu (
    input  logic               clk,
    input  logic               rst_n_i,
    stage_if.consumer          fetch,
    input  cpu_pkg::word_t     rdata1_i,
    input  cpu_pkg::word_t     rdata2_i,
    input  logic               jump_flag_i,
    output cpu_pkg::reg_addr_t raddr1_o,
    output cpu_pkg::reg_addr_t raddr2_o,
    stage_if.producer          issue
);
    import cpu_pkg::*;

    word_t   inst;
    opcode_e opc;
    word_t   imm_i, imm_b, imm_u, imm_j;
    issue_t  dec;
    logic    use_rs1, use_rs2;
    logic    hazard;

    // funct3 to alu op, alt is instruction bit 30
    function automatic alu_op_e alu_sel(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    function automatic bjp_op_e branch_sel(input logic [2:0] f3);
        case (f3)
            3'b000:  return BJP_BEQ;
            3'b001:  return BJP_BNE;
            3'b100:  return BJP_BLT;
            3'b101:  return BJP_BGE;
            3'b110:  return BJP_BLTU;
            3'b111:  return BJP_BGEU;
            default: return BJP_NONE;   // reserved funct3 never branches
        endcase
    endfunction

    assign inst     = fetch.payload;
    assign opc      = opcode_e'(inst[6:0]);
    assign raddr1_o = inst[19:15];
    assign raddr2_o = inst[24:20];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        dec         = '0;
        dec.pc      = fetch.pc;
        dec.op1     = rdata1_i;
        dec.op2     = rdata2_i;
        dec.rs2_val = rdata2_i;
        dec.rd      = inst[11:7];
        dec.alu_op  = ALU_ADD;
        dec.bjp_op  = BJP_NONE;
        use_rs1     = 1'b0;
        use_rs2     = 1'b0;
        case (opc)
            OPC_LUI: begin
                dec.imm    = imm_u;
                dec.op2    = imm_u;
                dec.alu_op = ALU_PASS;
                dec.rd_we  = 1'b1;
            end
            OPC_AUIPC: begin
                dec.imm   = imm_u;
                dec.op1   = fetch.pc;
                dec.op2   = imm_u;
                dec.rd_we = 1'b1;
            end
            OPC_JAL: begin
                dec.imm    = imm_j;
                dec.op1    = fetch.pc;
                dec.op2    = imm_j;
                dec.bjp_op = BJP_JAL;
                dec.rd_we  = 1'b1;
            end
            OPC_JALR: begin
                dec.imm    = imm_i;
                dec.op2    = imm_i;
                dec.bjp_op = BJP_JALR;
                dec.rd_we  = 1'b1;
                use_rs1    = 1'b1;
            end
            OPC_BRANCH: begin
                dec.imm    = imm_b;
                dec.bjp_op = branch_sel(inst[14:12]);
                use_rs1    = 1'b1;
                use_rs2    = 1'b1;
            end
            OPC_OP_IMM: begin
                dec.imm    = imm_i;
                dec.op2    = imm_i;
                // only srai sets bit 30 meaningfully, addi never turns into sub
                dec.alu_op = alu_sel(inst[14:12], inst[30] && inst[14:12] == 3'b101);
                dec.rd_we  = 1'b1;
                use_rs1    = 1'b1;
            end
            OPC_OP: begin
                dec.alu_op = alu_sel(inst[14:12], inst[30]);
                dec.rd_we  = !inst[25];  // mul/div group is not implemented
                use_rs1    = 1'b1;
                use_rs2    = 1'b1;
            end
            default: ;                   // unsupported, issues as a no-op
        endcase
        if (dec.rd == '0)
            dec.rd_we = 1'b0;
    end

    // raw on the instruction sitting in our issue register
    assign hazard = fetch.valid && issue.valid && issue.payload.rd_we &&
                    ((use_rs1 && raddr1_o == issue.payload.rd) ||
                     (use_rs2 && raddr2_o == issue.payload.rd));

    assign fetch.stall = hazard || issue.stall;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            issue.valid <= 1'b0;
        end else if (jump_flag_i) begin
            issue.valid <= 1'b0;                  // flush
        end else if (!issue.stall) begin
            issue.valid <= fetch.valid && !hazard; // bubble while stalled
        end
    end

    always_ff @(posedge clk) begin
        if (!issue.stall) begin
            issue.pc      <= fetch.pc;
            issue.payload <= dec;
        end
    end

endmodule

// File: src/ifu.sv
`timescale 1ns/1ns

module ifu (
    input  logic           clk,
    input  logic           rst_n_i,
    input  cpu_pkg::word_t inst_i,
    input  logic           jump_flag_i,
    input  cpu_pkg::word_t jump_addr_i,
    output cpu_pkg::word_t inst_addr_o,
    stage_if.producer      fetch
);
    import cpu_pkg::*;

    word_t pc_q;

    assign inst_addr_o = pc_q;   // memory answers in the same cycle

    // pc: redirect beats hold, hold beats increment
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pc_q <= RESET_PC;
        end else if (jump_flag_i) begin
            pc_q <= jump_addr_i;
        end else if (!fetch.stall) begin
            pc_q <= pc_q + INST_BYTES;
        end
    end

    // fetch/decode register, valid part
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            fetch.valid <= 1'b0;
        end else if (jump_flag_i) begin
            fetch.valid <= 1'b0;     // squash the word fetched on the wrong path
        end else if (!fetch.stall) begin
            fetch.valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!fetch.stall) begin
            fetch.pc      <= pc_q;
            fetch.payload <= inst_i;
        end
    end

endmodule

// File: src/stage_if.sv
`timescale 1ns/1ns

// one pipeline stage handing its output to the next
interface stage_if #(
    parameter type payload_t = cpu_pkg::word_t
) ();
    import cpu_pkg::*;

    logic     valid;
    word_t    pc;
    payload_t payload;
    logic     stall;    // consumer asks producer to hold

    modport producer (
        output valid,
        output pc,
        output payload,
        input  stall
    );

    modport consumer (
        input  valid,
        input  pc,
        input  payload,
        output stall
    );

endinterface

// File: verification/tb_ref_model.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

localparam int OPC_LUI    = 7'b0110111;
localparam int OPC_AUIPC  = 7'b0010111;
localparam int OPC_JAL    = 7'b1101111;
localparam int OPC_JALR   = 7'b1100111;
localparam int OPC_BRANCH = 7'b1100011;
localparam int OPC_OP_IMM = 7'b0010011;
localparam int OPC_OP     = 7'b0110011;
localparam logic [31:0] JAL_SELF = 32'h0000_006f;   // jal x0, 0

function automatic logic [31:0] enc_r(input int f7, input int rs2, input int rs1,
                                      input int f3, input int rd);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
endfunction

function automatic logic [31:0] enc_i(input int imm, input int rs1, input int f3,
                                      input int rd, input int op);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
endfunction

function automatic logic [31:0] enc_u(input int imm20, input int rd, input int op);
    return {imm20[19:0], rd[4:0], op[6:0]};
endfunction

function automatic logic [31:0] enc_b(input int imm, input int rs1, input int rs2,
                                      input int f3);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'b1100011};
endfunction

function automatic logic [31:0] enc_j(input int imm, input int rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
endfunction

// rv32i integer result by funct3
function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                        input logic [31:0] a, input logic [31:0] b);
    case (f3)
        3'd0:    return alt ? a - b : a + b;
        3'd1:    return a << b[4:0];
        3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'd3:    return (a < b) ? 32'd1 : 32'd0;
        3'd4:    return a ^ b;
        3'd5:    return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
        3'd6:    return a | b;
        default: return a & b;
    endcase
endfunction

function automatic logic branch_ref(input logic [2:0] f3, input logic [31:0] a,
                                    input logic [31:0] b);
    case (f3)
        3'd0:    return a == b;
        3'd1:    return a != b;
        3'd4:    return $signed(a) < $signed(b);
        3'd5:    return $signed(a) >= $signed(b);
        3'd6:    return a < b;
        3'd7:    return a >= b;
        default: return 1'b0;
    endcase
endfunction

// walks the rom at isa level and queues every register write
task automatic run_model;
    logic [31:0] x [32];
    logic [31:0] pc, nxt, ins, a, b, res, imm_i, imm_b;
    logic [4:0]  rd;
    logic [2:0]  f3;
    logic        wr;
    int          steps;
    for (int i = 0; i < 32; i++)
        x[i] = '0;
    pc = '0;
    steps = 0;
    while (steps < 4000) begin
        ins = rom[pc[9:2]];
        if (ins == JAL_SELF)
            break;
        rd    = ins[11:7];
        f3    = ins[14:12];
        a     = x[ins[19:15]];
        b     = x[ins[24:20]];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        nxt   = pc + 32'd4;
        res   = '0;
        wr    = 1'b0;
        case (ins[6:0])
            OPC_LUI[6:0]: begin
                res = {ins[31:12], 12'b0};
                wr  = 1'b1;
            end
            OPC_AUIPC[6:0]: begin
                res = pc + {ins[31:12], 12'b0};
                wr  = 1'b1;
            end
            OPC_JAL[6:0]: begin
                res = pc + 32'd4;
                wr  = 1'b1;
                nxt = pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            OPC_JALR[6:0]: begin
                res = pc + 32'd4;
                wr  = 1'b1;
                nxt = (a + imm_i) & ~32'd1;
            end
            OPC_BRANCH[6:0]: begin
                if (branch_ref(f3, a, b))
                    nxt = pc + imm_b;
            end
            OPC_OP_IMM[6:0]: begin
                res = alu_ref(f3, ins[30] && f3 == 3'd5, a, imm_i);
                wr  = 1'b1;
            end
            OPC_OP[6:0]: begin
                res = alu_ref(f3, ins[30], a, b);
                wr  = !ins[25];
            end
            default: ;   // anything else does nothing
        endcase
        if (wr && rd != 5'd0) begin
            x[rd] = res;
            exp_rd.push_back(rd);
            exp_val.push_back(res);
        end
        pc = nxt;
        steps++;
    end
endtask

`endif

// File: verification/tb_cpu_top.sv
`timescale 1ns/1ns

module tb_cpu_top;
    import cpu_pkg::*;

    logic      clk;
    logic      rst_n_i;
    word_t     inst_i;
    word_t     inst_addr_o;
    logic      wb_we_o;
    reg_addr_t wb_waddr_o;
    word_t     wb_wdata_o;

    word_t     rom [256];
    int        prog_len;
    reg_addr_t exp_rd [$];
    word_t     exp_val [$];
    int        widx;
    int        errors;
    int        checks;
    string     test_name;
    int        seed;
    logic      rst_q;      // reset level the core saw at the last rising edge

    `include "tb_ref_model.svh"

    cpu_top cpu_top_inst (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .inst_i     (inst_i),
        .inst_addr_o(inst_addr_o),
        .wb_we_o    (wb_we_o),
        .wb_waddr_o (wb_waddr_o),
        .wb_wdata_o (wb_wdata_o)
    );

    assign inst_i = rom[inst_addr_o[9:2]];   // combinational fetch

    initial clk = 1'b0;
    always #50 clk = ~clk;

    always @(posedge clk) begin
        rst_q <= rst_n_i;
    end

    // outputs are settled on the falling edge
    always @(negedge clk) begin
        if (!rst_q) begin
            // reset cycles and the cycle in which reset is released
            assert (inst_addr_o == RESET_PC && !wb_we_o) else begin
                errors++;
                $display("Fail %s reset: expected pc %h we 0, actual pc %h we %b",
                         test_name, RESET_PC, inst_addr_o, wb_we_o);
            end
        end else if (wb_we_o) begin
            checks++;
            assert (wb_waddr_o != '0) else begin
                errors++;
                $display("%s: a write to x0 reached the writeback port", test_name);
            end
            assert (widx < exp_rd.size()) else begin
                errors++;
                $display("%s: unexpected extra write x%0d = %h", test_name, wb_waddr_o,
                         wb_wdata_o);
            end
            if (widx < exp_rd.size()) begin
                assert (wb_waddr_o == exp_rd[widx] && wb_wdata_o == exp_val[widx]) else begin
                    errors++;
                    $display("Fail %s write %0d: expected x%0d=%h, actual x%0d=%h", test_name,
                             widx, exp_rd[widx], exp_val[widx], wb_waddr_o, wb_wdata_o);
                end
                widx++;
            end
        end
    end

    // hold the core in reset and start an empty program
    task automatic begin_test(input string name);
        @(posedge clk);
        #1 rst_n_i = 1'b0;
        test_name = name;
        for (int i = 0; i < 256; i++)
            rom[i] = '0;
        prog_len = 0;
        exp_rd.delete();
        exp_val.delete();
        widx = 0;
    endtask

    task automatic put(input word_t w);
        rom[prog_len[7:0]] = w;
        prog_len++;
    endtask

    task automatic run_test;
        int n;
        put(JAL_SELF);
        run_model();
        repeat (10) @(posedge clk);
        #1 rst_n_i = 1'b1;
        n = 0;
        while (widx < exp_rd.size() && n < 2000) begin
            @(posedge clk);
            n++;
        end
        if (widx < exp_rd.size()) begin
            errors++;
            $display("%s: timeout, %0d of %0d writes seen", test_name, widx, exp_rd.size());
        end
        repeat (20) @(posedge clk);   // room for stray writes
    endtask

    task automatic random_program;
        int r, rd, rs1, rs2, f3, alt, imm;
        for (int i = 0; i < 200; i++) begin
            r   = $random(seed);
            rd  = (r >>> 2) & 31;
            rs1 = (r >>> 7) & 31;
            rs2 = (r >>> 12) & 31;
            f3  = (r >>> 17) & 7;
            alt = (r >>> 20) & 1;
            imm = $random(seed);
            if ((r & 3) == 0)
                put(enc_u(imm, rd, OPC_LUI));
            else if ((r & 3) == 1)
                put(enc_r((alt != 0 && (f3 == 0 || f3 == 5)) ? 32 : 0, rs2, rs1, f3, rd));
            else if (f3 == 1)
                put(enc_i(imm & 31, rs1, f3, rd, OPC_OP_IMM));
            else if (f3 == 5)
                put(enc_i((imm & 31) | (alt << 10), rs1, f3, rd, OPC_OP_IMM));
            else
                put(enc_i(imm, rs1, f3, rd, OPC_OP_IMM));
        end
    endtask

    initial begin
        rst_n_i = 1'b0;
        errors  = 0;
        checks  = 0;
        seed    = 32'h9dc9359c;

        begin_test("alu");
        put(enc_i(-5, 0, 0, 1, OPC_OP_IMM));
        put(enc_u(32'h12345, 2, OPC_LUI));
        put(enc_i(32'h678, 2, 0, 2, OPC_OP_IMM));
        put(enc_r(0, 2, 1, 0, 3));          // add
        put(enc_r(32, 1, 2, 0, 4));         // sub
        put(enc_r(0, 1, 2, 1, 5));
        put(enc_r(0, 2, 1, 2, 6));
        put(enc_r(0, 2, 1, 3, 7));
        put(enc_r(0, 2, 1, 4, 8));
        put(enc_r(0, 2, 1, 5, 9));          // srl
        put(enc_r(32, 2, 1, 5, 10));        // sra
        put(enc_r(0, 2, 1, 6, 11));
        put(enc_r(0, 2, 1, 7, 12));
        put(enc_i(3, 1, 2, 13, OPC_OP_IMM));
        put(enc_i(3, 1, 3, 14, OPC_OP_IMM));
        put(enc_i(-1, 2, 4, 15, OPC_OP_IMM));
        put(enc_i(32'h0f0, 2, 6, 16, OPC_OP_IMM));
        put(enc_i(32'h0ff, 1, 7, 17, OPC_OP_IMM));
        put(enc_i(4, 2, 1, 18, OPC_OP_IMM));
        put(enc_i(3, 1, 5, 19, OPC_OP_IMM));
        put(enc_i(32'h403, 1, 5, 20, OPC_OP_IMM));   // srai
        put(enc_u(32'h10, 21, OPC_AUIPC));
        run_test();

        begin_test("hazard");
        put(enc_i(7, 0, 0, 1, OPC_OP_IMM));
        put(enc_i(3, 1, 0, 2, OPC_OP_IMM));  // distance 1
        put(enc_i(1, 0, 0, 3, OPC_OP_IMM));
        put(enc_r(0, 3, 2, 0, 4));           // distances 1 and 2
        put(enc_i(2, 0, 0, 5, OPC_OP_IMM));
        put(enc_i(3, 0, 0, 6, OPC_OP_IMM));
        put(enc_r(32, 5, 4, 0, 7));          // distances 3 and 2
        put(enc_r(0, 7, 7, 0, 8));
        run_test();

        begin_test("branch");
        put(enc_i(5, 0, 0, 1, OPC_OP_IMM));
        put(enc_i(-3, 0, 0, 2, OPC_OP_IMM));
        put(enc_b(8, 1, 1, 0));              // beq taken
        put(enc_i(99, 0, 0, 3, OPC_OP_IMM));
        put(enc_b(8, 1, 1, 1));              // bne not taken
        put(enc_i(1, 0, 0, 4, OPC_OP_IMM));
        put(enc_b(8, 2, 1, 4));              // blt taken
        put(enc_i(98, 0, 0, 3, OPC_OP_IMM));
        put(enc_b(8, 2, 1, 5));              // bge not taken
        put(enc_b(8, 2, 1, 6));              // bltu not taken
        put(enc_b(8, 2, 1, 7));              // bgeu taken
        put(enc_i(97, 0, 0, 3, OPC_OP_IMM));
        put(enc_j(12, 5));
        put(enc_i(96, 0, 0, 3, OPC_OP_IMM));
        put(enc_i(95, 0, 0, 3, OPC_OP_IMM));
        put(enc_i(76, 0, 0, 6, OPC_OP_IMM));
        put(enc_i(1, 6, 0, 7, OPC_JALR));    // bit 0 of target dropped
        put(enc_i(94, 0, 0, 3, OPC_OP_IMM));
        put(enc_i(93, 0, 0, 3, OPC_OP_IMM));
        put(enc_b(8, 1, 2, 1));              // bne taken
        put(enc_i(92, 0, 0, 3, OPC_OP_IMM));
        put(enc_b(8, 1, 2, 0));
        put(enc_b(8, 1, 2, 4));
        put(enc_b(8, 1, 2, 5));              // bge taken
        put(enc_i(91, 0, 0, 3, OPC_OP_IMM));
        put(enc_b(8, 1, 2, 6));              // bltu taken
        put(enc_i(90, 0, 0, 3, OPC_OP_IMM));
        put(enc_b(8, 1, 2, 7));
        put(enc_i(0, 7, 0, 8, OPC_OP_IMM));
        run_test();

        begin_test("x0");
        put(enc_i(9, 0, 0, 1, OPC_OP_IMM));
        put(enc_i(5, 0, 0, 0, OPC_OP_IMM));
        put(enc_r(0, 1, 1, 0, 0));
        put(enc_u(1, 0, OPC_LUI));
        put(enc_r(0, 1, 0, 0, 2));           // reads x0 right after the writes
        put(enc_i(0, 0, 6, 3, OPC_OP_IMM));
        put(enc_r(0, 0, 0, 0, 4));
        run_test();

        begin_test("random");
        random_program();
        run_test();

        $display("errors: %0d, writes checked: %0d", errors, checks);
        if (errors == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule
